// ==== include/otp_params.svh ====
/* otp fuse controller parameters
   array geometry, lock regions and command latencies */
`ifndef OTP_PARAMS_SVH
`define OTP_PARAMS_SVH

// fuse array geometry
`define OTP_ADDR_WIDTH      14
`define OTP_DEPTH           (1 << `OTP_ADDR_WIDTH)
`define OTP_WORD_WIDTH      32
`define OTP_WORD_SEL_WIDTH  5

// lock row, one region per eighth of the array
`define OTP_LOCK_REGIONS    8
`define OTP_REGION_WIDTH    3

// cycles from req_i to done_o
`define OTP_RD_CYCLES       3
`define OTP_PGM_CYCLES      6

`endif

// ==== src/otp_pkg.sv ====
/* otp controller types
   command encoding and the two views of a fuse bit address */
`default_nettype none

`include "otp_params.svh"

package otp_pkg;

  typedef enum logic [1:0] {
    OTP_CMD_READ = 2'd0,  // read one word
    OTP_CMD_PROG = 2'd1,  // program one bit
    OTP_CMD_LOCK = 2'd2   // lock one region
  } otp_cmd_e;

  // word field is whatever is left after region and bit select
  typedef struct packed {
    logic [`OTP_REGION_WIDTH-1:0]                                      region;
    logic [`OTP_ADDR_WIDTH-`OTP_REGION_WIDTH-`OTP_WORD_SEL_WIDTH-1:0] word;
    logic [`OTP_WORD_SEL_WIDTH-1:0]                                    bit_sel;
  } otp_addr_s;

  typedef union packed {
    logic [`OTP_ADDR_WIDTH-1:0] raw;  // flat bit address for programs
    otp_addr_s                  fld;  // region / word / bit view
  } otp_addr_u;

endpackage

`default_nettype wire

// ==== src/otp_macro_if.sv ====
/* otp macro bus
   strobes and address from the sequencer, read word and lock row back */
`default_nettype none

`include "otp_params.svh"

interface otp_macro_if import otp_pkg::*; ();

  logic                         ceb;       // chip enable, low active
  logic                         dle;       // data latch enable
  logic                         web;       // write pulse, low active
  logic                         pgmen;     // program enable
  logic                         cpumpen;   // charge pump enable
  logic                         readen;    // read enable
  logic                         lock_pgm;  // lock row program strobe
  otp_addr_u                    addr;
  logic                         din;
  logic [`OTP_WORD_WIDTH-1:0]   dout;
  logic [`OTP_LOCK_REGIONS-1:0] lock;

  modport master (
    output ceb, dle, web, pgmen, cpumpen, readen, lock_pgm, addr, din,
    input  dout, lock
  );

  modport slave (
    input  ceb, dle, web, pgmen, cpumpen, readen, lock_pgm, addr, din,
    output dout, lock
  );

endinterface

`default_nettype wire

// ==== src/otp_cmd_stage.sv ====
/* otp command stage
   takes a host request while idle and flags writes into locked regions */
`default_nettype none

`include "otp_params.svh"

module otp_cmd_stage import otp_pkg::*; (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         req_i,
  input  wire otp_cmd_e                     cmd_i,
  input  wire otp_addr_u                    addr_i,
  input  wire logic                         wbit_i,
  input  wire logic [`OTP_LOCK_REGIONS-1:0] lock_i,
  input  wire logic                         busy_i,
  output logic                              cmd_valid_o,
  output otp_cmd_e                          cmd_o,
  output otp_addr_u                         addr_o,
  output logic                              wbit_o,
  output logic                              reject_o
);

  logic accept;
  logic region_locked;
  logic is_write;

  assign accept        = req_i & ~busy_i;  // requests while busy are dropped
  assign region_locked = lock_i[addr_i.fld.region];
  assign is_write      = (cmd_i == OTP_CMD_PROG) || (cmd_i == OTP_CMD_LOCK);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= accept;  // single cycle pulse
    end
  end

  // request payload, only meaningful alongside cmd_valid_o
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_o    <= cmd_i;
      addr_o   <= addr_i;
      wbit_o   <= wbit_i;
      reject_o <= is_write & region_locked;  // reads always pass
    end
  end

endmodule

`default_nettype wire

// ==== src/otp_sequencer.sv ====
/* otp strobe sequencer
   walks the macro strobe order per command and reports done, error and read data */
`default_nettype none

`include "otp_params.svh"

module otp_sequencer import otp_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    cmd_valid_i,
  input  wire otp_cmd_e                cmd_i,
  input  wire otp_addr_u               addr_i,
  input  wire logic                    wbit_i,
  input  wire logic                    reject_i,
  otp_macro_if.master                  macro,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         err_o,
  output logic [`OTP_WORD_WIDTH-1:0]   rdata_o
);

  localparam int unsigned STEP_W = $clog2(`OTP_PGM_CYCLES);

  localparam logic [STEP_W-1:0] STEP_LATCH     = STEP_W'(0);  // dle + web with wbit
  localparam logic [STEP_W-1:0] STEP_BURN      = STEP_W'(2);  // program pulse
  localparam logic [STEP_W-1:0] STEP_LOCK_BURN = STEP_W'(1);  // lock pulse
  localparam logic [STEP_W-1:0] RD_LAST        = STEP_W'(`OTP_RD_CYCLES - 2);
  localparam logic [STEP_W-1:0] PGM_LAST       = STEP_W'(`OTP_PGM_CYCLES - 2);

  logic              active_q;
  logic [STEP_W-1:0] step_q;
  logic [STEP_W-1:0] last_step;
  otp_cmd_e          cmd_q;
  otp_addr_u         addr_q;
  logic              wbit_q;
  logic              reject_q;
  logic              is_read;

  assign is_read   = (cmd_q != OTP_CMD_PROG) && (cmd_q != OTP_CMD_LOCK);
  assign last_step = is_read ? RD_LAST : PGM_LAST;
  assign busy_o    = cmd_valid_i | active_q;  // covers the cycle before active_q rises

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      step_q   <= '0;
      done_o   <= 1'b0;
      err_o    <= 1'b0;
      rdata_o  <= '0;
    end else begin
      done_o <= 1'b0;
      err_o  <= 1'b0;
      if (cmd_valid_i) begin
        active_q <= 1'b1;
        step_q   <= '0;
      end else if (active_q) begin
        if (step_q == last_step) begin
          active_q <= 1'b0;
          done_o   <= 1'b1;
          err_o    <= reject_q;
          if (is_read) begin
            rdata_o <= macro.dout;  // word landed one cycle after readen
          end
        end else begin
          step_q <= step_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      cmd_q    <= cmd_i;
      addr_q   <= addr_i;
      wbit_q   <= wbit_i;
      reject_q <= reject_i;
    end
  end

  always_comb begin
    macro.ceb      = ~active_q;
    macro.dle      = 1'b0;
    macro.web      = 1'b1;
    macro.pgmen    = 1'b0;
    macro.cpumpen  = 1'b0;
    macro.readen   = 1'b0;
    macro.lock_pgm = 1'b0;
    macro.din      = 1'b0;
    macro.addr     = addr_q;
    if (active_q) begin
      case (cmd_q)
        OTP_CMD_PROG: begin
          if (!reject_q) begin  // rejected: steps still run, strobes stay idle
            macro.dle     = (step_q == STEP_LATCH);
            macro.din     = (step_q == STEP_LATCH) ? wbit_q : (step_q == STEP_BURN);
            macro.pgmen   = (step_q != STEP_LATCH) && (step_q != PGM_LAST);
            macro.cpumpen = (step_q != STEP_LATCH) && (step_q != PGM_LAST);
            macro.web     = ~((step_q == STEP_LATCH) || (step_q == STEP_BURN));
          end
        end
        OTP_CMD_LOCK: begin
          if (!reject_q) begin
            macro.lock_pgm = (step_q <= STEP_BURN);
            macro.cpumpen  = (step_q <= STEP_BURN);
            macro.web      = (step_q != STEP_LOCK_BURN);
          end
        end
        default: begin
          macro.readen = (step_q == '0);
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/otp_macro.sv ====
/* otp macro model
   bit-programmed fuse array with lock row and word-aligned 32-bit reads */
`default_nettype none

`include "otp_params.svh"

module otp_macro import otp_pkg::*; (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  otp_macro_if.slave macro
);

  logic [`OTP_DEPTH-1:0]        fuse_q;    // main array only
  logic [`OTP_LOCK_REGIONS-1:0] lock_q;
  logic [`OTP_WORD_WIDTH-1:0]   dout_q;
  logic                         din_latch_q;
  logic [`OTP_ADDR_WIDTH-1:0]   rd_base;
  logic                         latch_en;
  logic                         pgm_en;
  logic                         lock_en;
  logic                         rd_en;

  // low five address bits dropped for the word base
  assign rd_base = {macro.addr.fld.region, macro.addr.fld.word,
                    `OTP_WORD_SEL_WIDTH'(0)};

  assign latch_en = ~macro.web & macro.dle;
  assign pgm_en   = ~macro.web & macro.pgmen & macro.cpumpen & macro.din;
  assign lock_en  = ~macro.web & macro.lock_pgm & macro.cpumpen;
  assign rd_en    = macro.readen & ~macro.ceb;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      din_latch_q <= 1'b0;
    end else if (latch_en) begin
      din_latch_q <= macro.din;
    end
  end

  // fuses only blow, a latched 0 leaves the bit as it was
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fuse_q <= '0;
    end else if (pgm_en) begin
      fuse_q[macro.addr.raw] <= fuse_q[macro.addr.raw] | din_latch_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= '0;
    end else if (lock_en) begin
      lock_q[macro.addr.fld.region] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dout_q <= '0;
    end else if (rd_en) begin
      dout_q <= fuse_q[rd_base +: `OTP_WORD_WIDTH];  // holds until next read
    end
  end

  assign macro.dout = dout_q;
  assign macro.lock = lock_q;

endmodule

`default_nettype wire

// ==== src/otp_ctrl.sv ====
/* otp fuse controller top
   command stage, strobe sequencer and macro model joined by the macro bus */
`default_nettype none

`include "otp_params.svh"

module otp_ctrl import otp_pkg::*; (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         req_i,
  input  wire otp_cmd_e                     cmd_i,
  input  wire otp_addr_u                    addr_i,
  input  wire logic                         wbit_i,
  output logic                              busy_o,
  output logic                              done_o,
  output logic                              err_o,
  output logic [`OTP_WORD_WIDTH-1:0]        rdata_o,
  output logic [`OTP_LOCK_REGIONS-1:0]      lock_o
);

  logic      cmd_valid;
  otp_cmd_e  cmd;
  otp_addr_u addr;
  logic      wbit;
  logic      reject;

  otp_macro_if macro_if ();

  otp_cmd_stage otp_cmd_stage_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .cmd_i       (cmd_i),
    .addr_i      (addr_i),
    .wbit_i      (wbit_i),
    .lock_i      (macro_if.lock),  // live lock row for the reject check
    .busy_i      (busy_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .addr_o      (addr),
    .wbit_o      (wbit),
    .reject_o    (reject)
  );

  otp_sequencer otp_sequencer_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .addr_i      (addr),
    .wbit_i      (wbit),
    .reject_i    (reject),
    .macro       (macro_if.master),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .err_o       (err_o),
    .rdata_o     (rdata_o)
  );

  otp_macro otp_macro_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .macro    (macro_if.slave)
  );

  assign lock_o = macro_if.lock;

endmodule

`default_nettype wire

// ==== testbench/otp_ctrl_tb.sv ====
/* otp fuse controller testbench
   directed tests against a reference fuse array and lock row */
`default_nettype none

`include "otp_params.svh"

module otp_ctrl_tb import otp_pkg::*; ();

  localparam int NUM_REQUESTS    = 52;  // requests issued by all tests together
  localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (`OTP_PGM_CYCLES + 4) + 100;

  logic                         clk_i, arst_n_i, req_i, wbit_i;
  otp_cmd_e                     cmd_i;
  otp_addr_u                    addr_i;
  logic                         busy_o, done_o, err_o;
  logic [`OTP_WORD_WIDTH-1:0]   rdata_o;
  logic [`OTP_LOCK_REGIONS-1:0] lock_o;

  logic [`OTP_DEPTH-1:0]        ref_fuse;  // reference fuse array
  logic [`OTP_LOCK_REGIONS-1:0] ref_lock;
  otp_addr_u                    prog_addr [12];
  int                           error_count, tests_run, tests_failed;

  otp_ctrl otp_ctrl_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  task automatic check_word(input string test, input logic [`OTP_WORD_WIDTH-1:0] exp,
                            input logic [`OTP_WORD_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", test, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s: expected %b, actual %b", test, exp, act);
      error_count++;
    end
  endtask

  task automatic check_lock(input string test, input logic [`OTP_LOCK_REGIONS-1:0] exp,
                            input logic [`OTP_LOCK_REGIONS-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", test, exp, act);
      error_count++;
    end
  endtask

  // 32 bits from the word-aligned base of a
  function automatic logic [`OTP_WORD_WIDTH-1:0] ref_word(input otp_addr_u a);
    logic [`OTP_WORD_WIDTH-1:0] w;
    for (int i = 0; i < `OTP_WORD_WIDTH; i++) begin
      w[i] = ref_fuse[{a.raw[`OTP_ADDR_WIDTH-1:`OTP_WORD_SEL_WIDTH], 5'd0} + i];
    end
    return w;
  endfunction

  function automatic void update_model(input otp_cmd_e cmd, input otp_addr_u a,
                                       input logic wbit);
    if (cmd == OTP_CMD_LOCK) begin
      ref_lock[a.fld.region] = 1'b1;
    end else if (cmd == OTP_CMD_PROG && wbit && !ref_lock[a.fld.region]) begin
      ref_fuse[a.raw] = 1'b1;  // fuses only go 0 to 1
    end
  endfunction

  function automatic otp_addr_u rand_addr(input logic [2:0] region);
    otp_addr_u a;
    a.raw        = 14'($urandom);
    a.fld.region = region;
    return a;
  endfunction

  task automatic drive_req(input otp_cmd_e cmd, input otp_addr_u a, input logic wbit);
    @(posedge clk_i);
    req_i  <= 1'b1;
    cmd_i  <= cmd;
    addr_i <= a;
    wbit_i <= wbit;
    @(posedge clk_i);
    req_i  <= 1'b0;  // request sampled on this edge
  endtask

  // counts edges after the sampling edge, elapsed already spent by the caller
  task automatic wait_done(input string test, input int latency, input int elapsed,
                           output logic seen);
    int n;
    seen = 1'b0;
    n    = elapsed;
    while (!seen && n < latency) begin
      @(posedge clk_i);
      #1;
      n++;
      if (done_o) begin
        seen = 1'b1;
        if (n < latency) begin
          $display("error: %s: done early after %0d of %0d cycles", test, n, latency);
          error_count++;
        end
      end
    end
    if (!seen) begin
      $display("error: %s: done missing after %0d cycles", test, latency);
      error_count++;
    end
  endtask

  task automatic issue(input string test, input otp_cmd_e cmd, input otp_addr_u a,
                       input logic wbit);
    logic                       exp_err;
    logic [`OTP_WORD_WIDTH-1:0] exp_word;
    logic                       seen;
    exp_err  = (cmd != OTP_CMD_READ) && ref_lock[a.fld.region];
    exp_word = ref_word(a);
    drive_req(cmd, a, wbit);
    wait_done(test, (cmd == OTP_CMD_READ) ? `OTP_RD_CYCLES : `OTP_PGM_CYCLES, 0, seen);
    if (seen) begin
      check_flag(test, exp_err, err_o);
      check_flag(test, 1'b0, busy_o);  // busy drops together with done
      if (cmd == OTP_CMD_READ) begin
        check_word(test, exp_word, rdata_o);
      end
    end
    update_model(cmd, a, wbit);
  endtask

  task automatic report_test(input string test, input int base_errors);
    tests_run++;
    if (error_count == base_errors) begin
      $display("test %s: pass", test);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", test, error_count - base_errors);
    end
  endtask

  task automatic test_reset();
    int base_errors;
    base_errors = error_count;
    check_flag("reset", 1'b0, busy_o);
    check_flag("reset", 1'b0, done_o);
    check_flag("reset", 1'b0, err_o);
    check_lock("reset", '0, lock_o);
    check_word("reset", '0, rdata_o);
    for (int r = 0; r < 8; r += 2) begin
      issue("reset", OTP_CMD_READ, rand_addr(3'(r)), 1'b0);
    end
    report_test("reset", base_errors);
  endtask

  task automatic test_program();
    otp_addr_u a;
    int        base_errors;
    base_errors = error_count;
    for (int i = 0; i < 12; i++) begin
      prog_addr[i] = rand_addr(3'($urandom_range(3)));
      issue("program", OTP_CMD_PROG, prog_addr[i], 1'b1);
    end
    for (int i = 0; i < 4; i++) begin
      a             = prog_addr[i];
      a.fld.bit_sel = a.fld.bit_sel ^ 5'd1;  // neighbour bit, written with 0
      issue("program", OTP_CMD_PROG, a, 1'b0);
    end
    for (int i = 0; i < 12; i++) begin
      issue("program", OTP_CMD_READ, prog_addr[i], 1'b0);
    end
    report_test("program", base_errors);
  endtask

  task automatic test_alias();
    otp_addr_u a;
    int        base_errors;
    base_errors = error_count;
    for (int i = 0; i < 4; i++) begin
      a             = prog_addr[i];
      a.fld.bit_sel = '0;
      issue("alias", OTP_CMD_READ, a, 1'b0);
      a.fld.bit_sel = 5'($urandom);
      issue("alias", OTP_CMD_READ, a, 1'b0);
    end
    report_test("alias", base_errors);
  endtask

  task automatic test_lock();
    otp_addr_u a;
    int        base_errors;
    base_errors = error_count;
    issue("lock", OTP_CMD_LOCK, rand_addr(3'd5), 1'b0);
    check_lock("lock", 8'h20, lock_o);
    a = rand_addr(3'd5);
    issue("lock", OTP_CMD_PROG, a, 1'b1);  // rejected, err high
    issue("lock", OTP_CMD_READ, a, 1'b0);
    a = rand_addr(3'd2);
    issue("lock", OTP_CMD_PROG, a, 1'b1);
    issue("lock", OTP_CMD_READ, a, 1'b0);
    issue("lock", OTP_CMD_LOCK, rand_addr(3'd5), 1'b0);  // already locked
    check_lock("lock", 8'h20, lock_o);
    report_test("lock", base_errors);
  endtask

  task automatic test_busy_drop();
    otp_addr_u a, b;
    logic      seen;
    int        extra;
    int        base_errors;
    base_errors   = error_count;
    a             = rand_addr(3'd6);
    b             = a;
    b.fld.bit_sel = a.fld.bit_sel ^ 5'd2;  // same word, other bit
    drive_req(OTP_CMD_PROG, a, 1'b1);
    @(posedge clk_i);
    req_i  <= 1'b1;  // second request while busy
    addr_i <= b;
    #1;
    check_flag("busy_drop", 1'b1, busy_o);
    @(posedge clk_i);
    req_i <= 1'b0;
    wait_done("busy_drop", `OTP_PGM_CYCLES, 2, seen);
    if (seen) begin
      check_flag("busy_drop", 1'b0, err_o);
    end
    update_model(OTP_CMD_PROG, a, 1'b1);
    extra = 0;
    repeat (`OTP_PGM_CYCLES + 2) begin
      @(posedge clk_i);
      #1;
      if (done_o) extra++;
    end
    if (extra != 0) begin
      $display("error: busy_drop: done raised for a request made while busy");
      error_count++;
    end
    issue("busy_drop", OTP_CMD_READ, a, 1'b0);
    report_test("busy_drop", base_errors);
  endtask

  task automatic test_latency();
    int base_errors;
    base_errors = error_count;
    issue("latency", OTP_CMD_READ, rand_addr(3'd1), 1'b0);
    issue("latency", OTP_CMD_PROG, rand_addr(3'd0), 1'b1);
    issue("latency", OTP_CMD_PROG, rand_addr(3'd5), 1'b1);  // rejected program
    report_test("latency", base_errors);
  endtask

  initial begin
    arst_n_i     = 1'b0;
    req_i        = 1'b0;
    cmd_i        = OTP_CMD_READ;
    addr_i       = '0;
    wbit_i       = 1'b0;
    ref_fuse     = '0;
    ref_lock     = '0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'he723_11a6));
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    #1;
    test_reset();
    test_program();
    test_alias();
    test_lock();
    test_busy_drop();
    test_latency();
    $display("%0d tests run, %0d passed, %0d failed", tests_run,
             tests_run - tests_failed, tests_failed);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== otp_ctrl.f ====
+incdir+include
src/otp_pkg.sv
src/otp_macro_if.sv
src/otp_cmd_stage.sv
src/otp_sequencer.sv
src/otp_macro.sv
src/otp_ctrl.sv
testbench/otp_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: otp_ctrl

sources:
  - include_dirs:
      - include
    files:
      - src/otp_pkg.sv
      - src/otp_macro_if.sv
      - src/otp_cmd_stage.sv
      - src/otp_sequencer.sv
      - src/otp_macro.sv
      - src/otp_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/otp_ctrl_tb.sv
